//--- design/mem_geom_pkg.sv
`default_nettype none

// -----------------------------------------------------------------------
// Memory geometry shared by the arbiter, the storage array and the top
// -----------------------------------------------------------------------
package mem_geom_pkg;

    // One line is the unit of every access
    localparam int LINE_W = 128;

    // Client address width, only the low INDEX_W bits select a line
    localparam int ADDR_W = 32;

    // Number of lines held by the storage array
    localparam int MEM_DEPTH = 256;

    // Line index width, follows the depth
    localparam int INDEX_W = $clog2(MEM_DEPTH);

endpackage : mem_geom_pkg

`default_nettype wire

//--- design/mem_ctrl_pkg.sv
`default_nettype none

// -----------------------------------------------------------------------
// Client count and configuration register map
// -----------------------------------------------------------------------
package mem_ctrl_pkg;

    localparam int NUM_WR      = 4;              // Render-tile writers
    localparam int NUM_CLIENTS = NUM_WR + 1;     // Writers plus the reader slot
    localparam int SLOT_W      = $clog2(NUM_CLIENTS);

    // Register port geometry
    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 32;

    // Register addresses
    localparam logic [CFG_ADDR_W-1:0] REG_CTRL     = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_WR_COUNT = 2'd1;  // Read only

    // REG_CTRL field positions
    localparam int CTRL_MASK_LSB     = 0;        // Enable mask in bits 3..0
    localparam int CTRL_MC_FIRST_BIT = 8;

    // All writers enabled, mc_first clear
    localparam logic [CFG_DATA_W-1:0] CTRL_RESET = 32'h0000_000F;

    // Completed-write counter width
    localparam int CNT_W = 16;

endpackage : mem_ctrl_pkg

`default_nettype wire

//--- design/mem_access_if.sv
`timescale 1ns/1ps
`default_nettype none

// -----------------------------------------------------------------------
// The single access chosen per cycle, arbiter to storage array
// -----------------------------------------------------------------------
interface mem_access_if;

    logic                               wr_en;
    logic [mem_geom_pkg::INDEX_W-1:0]   wr_index;
    logic [mem_geom_pkg::LINE_W-1:0]    wr_data;
    logic                               rd_en;
    logic [mem_geom_pkg::INDEX_W-1:0]   rd_index;
    logic [mem_geom_pkg::LINE_W-1:0]    rd_data;   // Valid the cycle after rd_en

    // Arbiter side
    modport arb (
        output wr_en, wr_index, wr_data,
        output rd_en, rd_index,
        input  rd_data
    );

    // Storage side
    modport store (
        input  wr_en, wr_index, wr_data,
        input  rd_en, rd_index,
        output rd_data
    );

endinterface : mem_access_if

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                                 clk,
    input  wire                                 rst_n,
    // Writers
    input  wire  [mem_ctrl_pkg::NUM_WR-1:0]     we_rt,
    input  wire  [mem_geom_pkg::ADDR_W-1:0]     addr_rt [mem_ctrl_pkg::NUM_WR],
    input  wire  [mem_geom_pkg::LINE_W-1:0]     data_rt_in [mem_ctrl_pkg::NUM_WR],
    // Reader
    input  wire                                 re_mc,
    input  wire  [mem_geom_pkg::ADDR_W-1:0]     addr_mc,
    output logic [mem_ctrl_pkg::NUM_WR-1:0]     rdy_rt,
    output logic                                rdy_mc,
    output logic [mem_geom_pkg::LINE_W-1:0]     data_mc_out,
    // Register block
    input  wire  [mem_ctrl_pkg::NUM_WR-1:0]     wr_enable_mask,
    input  wire                                 mc_first,
    output logic                                wr_done,
    // Chosen access
    mem_access_if.arb                           acc
);

    logic [mem_ctrl_pkg::SLOT_W-1:0]      last_slot;    // Slot chosen most recently
    logic [mem_ctrl_pkg::SLOT_W-1:0]      grant_slot;
    logic                                 grant_vld;
    logic [mem_ctrl_pkg::NUM_CLIENTS-1:0] req_elig;
    logic [mem_ctrl_pkg::NUM_CLIENTS-1:0] grant;
    logic                                 rd_inflight;

    // Reader sits in the top slot and is blocked while its result is pending
    assign req_elig = {re_mc & ~rd_inflight, we_rt & wr_enable_mask};

    // -------------------------------------------------------------------
    // Choice of one client per cycle
    // -------------------------------------------------------------------
    always_comb begin
        int idx;
        grant_vld  = 1'b0;
        grant_slot = last_slot;
        idx        = 0;
        if (mc_first && req_elig[mem_ctrl_pkg::NUM_WR]) begin
            grant_vld  = 1'b1;
            grant_slot = mem_ctrl_pkg::SLOT_W'(mem_ctrl_pkg::NUM_WR);
        end else begin
            // Scan the rotation starting just past the last winner
            for (int k = 1; k <= mem_ctrl_pkg::NUM_CLIENTS; k++) begin
                idx = (int'(last_slot) + k) % mem_ctrl_pkg::NUM_CLIENTS;
                if (!grant_vld && req_elig[idx]) begin
                    grant_vld  = 1'b1;
                    grant_slot = idx[mem_ctrl_pkg::SLOT_W-1:0];
                end
            end
        end
        grant = '0;
        if (grant_vld)
            grant[grant_slot] = 1'b1;
    end

    // -------------------------------------------------------------------
    // Drive the chosen access
    // -------------------------------------------------------------------
    always_comb begin
        acc.wr_en    = 1'b0;
        acc.wr_index = '0;
        acc.wr_data  = '0;
        for (int i = 0; i < mem_ctrl_pkg::NUM_WR; i++) begin
            if (grant[i]) begin
                acc.wr_en    = 1'b1;
                acc.wr_index = addr_rt[i][mem_geom_pkg::INDEX_W-1:0];
                acc.wr_data  = data_rt_in[i];
            end
        end
        acc.rd_en    = grant[mem_ctrl_pkg::NUM_WR];
        acc.rd_index = addr_mc[mem_geom_pkg::INDEX_W-1:0];  // Upper bits ignored
    end

    // Write ready marks the chosen cycle itself
    assign rdy_rt  = grant[mem_ctrl_pkg::NUM_WR-1:0];
    assign wr_done = |rdy_rt;

    // Pointer and read tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_slot   <= mem_ctrl_pkg::SLOT_W'(mem_ctrl_pkg::NUM_WR);  // Writer 0 goes first
            rd_inflight <= 1'b0;
        end else begin
            if (grant_vld)
                last_slot <= grant_slot;
            rd_inflight <= acc.rd_en;   // Result returns next cycle
        end
    end

    // Read result is shown only in its ready cycle
    assign rdy_mc      = rd_inflight;
    assign data_mc_out = rd_inflight ? acc.rd_data : '0;

endmodule : mem_arbiter

`default_nettype wire

//--- design/mem_array.sv
`timescale 1ns/1ps
`default_nettype none

// -----------------------------------------------------------------------
// Single-ported line storage, one access per cycle
// -----------------------------------------------------------------------
module mem_array (
    input  wire         clk,
    mem_access_if.store acc
);

    logic [mem_geom_pkg::LINE_W-1:0] lines [mem_geom_pkg::MEM_DEPTH];

    // The arbiter never raises wr_en and rd_en together
    always_ff @(posedge clk) begin
        if (acc.wr_en)
            lines[acc.wr_index] <= acc.wr_data;
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (acc.rd_en)
            acc.rd_data <= lines[acc.rd_index];  // Ready one cycle later
    end

endmodule : mem_array

`default_nettype wire

//--- design/mem_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mem_cfg_regs (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     cfg_we,
    input  wire                                     cfg_re,
    input  wire  [mem_ctrl_pkg::CFG_ADDR_W-1:0]     cfg_addr,
    input  wire  [mem_ctrl_pkg::CFG_DATA_W-1:0]     cfg_wdata,
    output logic [mem_ctrl_pkg::CFG_DATA_W-1:0]     cfg_rdata,
    input  wire                                     wr_done,
    output logic [mem_ctrl_pkg::NUM_WR-1:0]         wr_enable_mask,
    output logic                                    mc_first
);

    logic [mem_ctrl_pkg::CNT_W-1:0]      wr_count;
    logic [mem_ctrl_pkg::CFG_DATA_W-1:0] ctrl_word;

    // -------------------------------------------------------------------
    // REG_CTRL fields
    // -------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_enable_mask <=
                mem_ctrl_pkg::CTRL_RESET[mem_ctrl_pkg::CTRL_MASK_LSB +: mem_ctrl_pkg::NUM_WR];
            mc_first       <= mem_ctrl_pkg::CTRL_RESET[mem_ctrl_pkg::CTRL_MC_FIRST_BIT];
        end else if (cfg_we && cfg_addr == mem_ctrl_pkg::REG_CTRL) begin
            wr_enable_mask <= cfg_wdata[mem_ctrl_pkg::CTRL_MASK_LSB +: mem_ctrl_pkg::NUM_WR];
            mc_first       <= cfg_wdata[mem_ctrl_pkg::CTRL_MC_FIRST_BIT];
        end
    end

    // Completed writes, wraps at the top
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_count <= '0;
        else if (wr_done)
            wr_count <= wr_count + 1'b1;
    end

    // Readback image of REG_CTRL with unused bits zero
    always_comb begin
        ctrl_word = '0;
        ctrl_word[mem_ctrl_pkg::CTRL_MASK_LSB +: mem_ctrl_pkg::NUM_WR] = wr_enable_mask;
        ctrl_word[mem_ctrl_pkg::CTRL_MC_FIRST_BIT]                     = mc_first;
    end

    // -------------------------------------------------------------------
    // Registered readback
    // -------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rdata <= '0;
        end else if (cfg_re) begin
            case (cfg_addr)
                mem_ctrl_pkg::REG_CTRL:     cfg_rdata <= ctrl_word;
                mem_ctrl_pkg::REG_WR_COUNT: cfg_rdata <= mem_ctrl_pkg::CFG_DATA_W'(wr_count);
                default:                    cfg_rdata <= '0;
            endcase
        end
    end

endmodule : mem_cfg_regs

`default_nettype wire

//--- design/mem_main.sv
`timescale 1ns/1ps
`default_nettype none

// -----------------------------------------------------------------------
// Shared line memory with four writers, one reader and a register port
// -----------------------------------------------------------------------
module mem_main (
    input  wire                                 clk,
    input  wire                                 rst_n,
    // Render-tile writers
    input  wire  [mem_ctrl_pkg::NUM_WR-1:0]     we_rt,
    input  wire  [mem_geom_pkg::ADDR_W-1:0]     addr_rt [mem_ctrl_pkg::NUM_WR],
    input  wire  [mem_geom_pkg::LINE_W-1:0]     data_rt_in [mem_ctrl_pkg::NUM_WR],
    output wire  [mem_ctrl_pkg::NUM_WR-1:0]     rdy_rt,
    // Memory-client reader
    input  wire                                 re_mc,
    input  wire  [mem_geom_pkg::ADDR_W-1:0]     addr_mc,
    output wire  [mem_geom_pkg::LINE_W-1:0]     data_mc_out,
    output wire                                 rdy_mc,
    // Configuration port
    input  wire                                 cfg_we,
    input  wire                                 cfg_re,
    input  wire  [mem_ctrl_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  wire  [mem_ctrl_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output wire  [mem_ctrl_pkg::CFG_DATA_W-1:0] cfg_rdata
);

    wire [mem_ctrl_pkg::NUM_WR-1:0] wr_enable_mask;
    wire                            mc_first;
    wire                            wr_done;   // One pulse per stored line

    mem_access_if acc_if ();

    // -------------------------------------------------------------------
    // Arbiter
    // -------------------------------------------------------------------
    mem_arbiter u_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .we_rt          (we_rt),
        .addr_rt        (addr_rt),
        .data_rt_in     (data_rt_in),
        .re_mc          (re_mc),
        .addr_mc        (addr_mc),
        .rdy_rt         (rdy_rt),
        .rdy_mc         (rdy_mc),
        .data_mc_out    (data_mc_out),
        .wr_enable_mask (wr_enable_mask),
        .mc_first       (mc_first),
        .wr_done        (wr_done),
        .acc            (acc_if.arb)
    );

    // Line storage
    mem_array u_array (
        .clk (clk),
        .acc (acc_if.store)
    );

    // -------------------------------------------------------------------
    // Configuration and status registers
    // -------------------------------------------------------------------
    mem_cfg_regs u_cfg_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_we         (cfg_we),
        .cfg_re         (cfg_re),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata),
        .wr_done        (wr_done),
        .wr_enable_mask (wr_enable_mask),
        .mc_first       (mc_first)
    );

endmodule : mem_main

`default_nettype wire

//--- verification/mem_main_sva.sv
`timescale 1ns/1ps
`default_nettype none

// -----------------------------------------------------------------------
// Grant and ready rules of the shared memory, bound into mem_main
// -----------------------------------------------------------------------
module mem_main_sva (
    input wire                              clk,
    input wire                              rst_n,
    input wire [mem_ctrl_pkg::NUM_WR-1:0]   we_rt,
    input wire [mem_ctrl_pkg::NUM_WR-1:0]   rdy_rt,
    input wire [mem_ctrl_pkg::NUM_WR-1:0]   wr_enable_mask,
    input wire                              re_mc,
    input wire                              rdy_mc
);

    // Only one writer is served per cycle
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rdy_rt))
        else $error("More than one writer ready in the same cycle");

    // A ready writer must be requesting and enabled
    assert property (@(posedge clk) disable iff (!rst_n)
        (rdy_rt & ~(we_rt & wr_enable_mask)) == '0)
        else $error("Writer ready without request or enable");

    // No back-to-back read results for one held request
    assert property (@(posedge clk) disable iff (!rst_n)
        (rdy_mc && re_mc) |=> !rdy_mc)
        else $error("Reader ready on two consecutive cycles");

endmodule : mem_main_sva

bind mem_main mem_main_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .we_rt          (we_rt),
    .rdy_rt         (rdy_rt),
    .wr_enable_mask (wr_enable_mask),
    .re_mc          (re_mc),
    .rdy_mc         (rdy_mc)
);

`default_nettype wire

//--- verification/tb_mem_main.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_main;

    localparam int          CLK_PERIOD    = 40;
    localparam int          WAIT_LIMIT    = 50;     // Cycles before a wait gives up
    localparam int          DISABLED_WAIT = 20;     // Cycles a disabled writer is watched
    localparam logic [31:0] SEED          = 32'h1c4a;

    logic                                   clk;
    logic                                   rst_n;
    logic [mem_ctrl_pkg::NUM_WR-1:0]        we_rt;
    logic [mem_geom_pkg::ADDR_W-1:0]        addr_rt [mem_ctrl_pkg::NUM_WR];
    logic [mem_geom_pkg::LINE_W-1:0]        data_rt_in [mem_ctrl_pkg::NUM_WR];
    wire  [mem_ctrl_pkg::NUM_WR-1:0]        rdy_rt;
    logic                                   re_mc;
    logic [mem_geom_pkg::ADDR_W-1:0]        addr_mc;
    wire  [mem_geom_pkg::LINE_W-1:0]        data_mc_out;
    wire                                    rdy_mc;
    logic                                   cfg_we;
    logic                                   cfg_re;
    logic [mem_ctrl_pkg::CFG_ADDR_W-1:0]    cfg_addr;
    logic [mem_ctrl_pkg::CFG_DATA_W-1:0]    cfg_wdata;
    wire  [mem_ctrl_pkg::CFG_DATA_W-1:0]    cfg_rdata;

    logic [mem_geom_pkg::LINE_W-1:0]        model [mem_geom_pkg::MEM_DEPTH];  // Expected lines
    logic [mem_geom_pkg::INDEX_W-1:0]       kept_idx;   // A line kept for later reads
    int                                     wr_pulses = 0;

    mem_main DUT (
        .clk (clk), .rst_n (rst_n),
        .we_rt (we_rt), .addr_rt (addr_rt), .data_rt_in (data_rt_in), .rdy_rt (rdy_rt),
        .re_mc (re_mc), .addr_mc (addr_mc), .data_mc_out (data_mc_out), .rdy_mc (rdy_mc),
        .cfg_we (cfg_we), .cfg_re (cfg_re), .cfg_addr (cfg_addr),
        .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Each ready writer stores its line at the end of that cycle
    always @(negedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < mem_ctrl_pkg::NUM_WR; i++) begin
                if (rdy_rt[i]) begin
                    model[addr_rt[i][mem_geom_pkg::INDEX_W-1:0]] = data_rt_in[i];
                    wr_pulses++;
                end
            end
        end
    end

    // -------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string test, input logic [mem_geom_pkg::LINE_W-1:0] expected,
                               input logic [mem_geom_pkg::LINE_W-1:0] actual);
        if (expected !== actual)
            stop_on_error($sformatf("MISMATCH %s expected %0h actual %0h", test, expected, actual));
    endtask

    function automatic logic [mem_geom_pkg::LINE_W-1:0] rand_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Random upper bits, which the DUT must ignore
    function automatic logic [mem_geom_pkg::ADDR_W-1:0] line_addr(
        input logic [mem_geom_pkg::INDEX_W-1:0] idx);
        logic [mem_geom_pkg::ADDR_W-1:0] a;
        a = $urandom();
        a[mem_geom_pkg::INDEX_W-1:0] = idx;
        return a;
    endfunction

    task automatic wait_write_ready(input int wr);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!rdy_rt[wr]) begin
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_error($sformatf("Timeout waiting for the ready of writer %0d", wr));
            @(negedge clk);
        end
    endtask

    task automatic write_line(input int wr, input logic [mem_geom_pkg::INDEX_W-1:0] idx,
                              input logic [mem_geom_pkg::LINE_W-1:0] data);
        @(posedge clk);
        we_rt[wr]      <= 1'b1;
        addr_rt[wr]    <= line_addr(idx);
        data_rt_in[wr] <= data;
        wait_write_ready(wr);
        @(posedge clk);
        we_rt[wr]      <= 1'b0;
    endtask

    // Cycles counts the sampled cycles up to and including the ready one
    task automatic read_line(input logic [mem_geom_pkg::INDEX_W-1:0] idx,
                             output logic [mem_geom_pkg::LINE_W-1:0] data, output int cycles);
        @(posedge clk);
        re_mc   <= 1'b1;
        addr_mc <= line_addr(idx);
        cycles  = 1;
        @(negedge clk);
        while (!rdy_mc) begin
            cycles++;
            if (cycles > WAIT_LIMIT)
                stop_on_error("Timeout waiting for the read result");
            @(negedge clk);
        end
        data = data_mc_out;
        @(posedge clk);
        re_mc <= 1'b0;
    endtask

    task automatic cfg_write(input logic [mem_ctrl_pkg::CFG_ADDR_W-1:0] addr,
                             input logic [mem_ctrl_pkg::CFG_DATA_W-1:0] data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we    <= 1'b0;
    endtask

    task automatic cfg_read(input logic [mem_ctrl_pkg::CFG_ADDR_W-1:0] addr,
                            output logic [mem_ctrl_pkg::CFG_DATA_W-1:0] data);
        @(posedge clk);
        cfg_re   <= 1'b1;
        cfg_addr <= addr;
        @(posedge clk);
        cfg_re   <= 1'b0;
        @(negedge clk);
        data = cfg_rdata;   // Registered one cycle after cfg_re
    endtask

    // -------------------------------------------------------------------
    // Directed tests
    // -------------------------------------------------------------------
    task automatic test_reset();
        logic [mem_ctrl_pkg::CFG_DATA_W-1:0] val;
        @(negedge clk);
        check_value("reset rdy_rt", '0, rdy_rt);
        check_value("reset rdy_mc", '0, rdy_mc);
        check_value("reset data_mc_out", '0, data_mc_out);
        cfg_read(mem_ctrl_pkg::REG_CTRL, val);
        check_value("reset REG_CTRL", mem_ctrl_pkg::CTRL_RESET, val);
        cfg_read(mem_ctrl_pkg::REG_WR_COUNT, val);
        check_value("reset REG_WR_COUNT", '0, val);
    endtask

    task automatic test_single();
        logic [mem_geom_pkg::INDEX_W-1:0] idx;
        logic [mem_geom_pkg::LINE_W-1:0]  got;
        int                               cycles;
        idx = $urandom();
        write_line(0, idx, rand_line());
        read_line(idx, got, cycles);
        check_value("single write read", model[idx], got);
    endtask

    task automatic test_concurrent();
        logic [mem_geom_pkg::INDEX_W-1:0] idx [mem_ctrl_pkg::NUM_WR];
        logic [mem_ctrl_pkg::NUM_WR-1:0]  seen;
        logic [mem_geom_pkg::LINE_W-1:0]  got;
        int                               cycles;
        int                               waited;
        @(posedge clk);
        for (int i = 0; i < mem_ctrl_pkg::NUM_WR; i++) begin
            idx[i]        = 8'(i * 64 + ($urandom() % 63));   // Distinct, never offset 63
            addr_rt[i]    <= line_addr(idx[i]);
            data_rt_in[i] <= rand_line();
        end
        we_rt  <= '1;
        seen   = '0;
        waited = 0;
        while (seen != '1) begin
            @(negedge clk);
            if ((rdy_rt & seen) != '0)
                stop_on_error("A writer saw a second ready pulse for one write");
            seen = seen | rdy_rt;
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_error("Timeout waiting for all four writers to be served");
            @(posedge clk);
            we_rt <= ~seen;    // Served writers drop their request
        end
        for (int i = 0; i < mem_ctrl_pkg::NUM_WR; i++) begin
            read_line(idx[i], got, cycles);
            check_value($sformatf("concurrent read of writer %0d", i), model[idx[i]], got);
        end
        kept_idx = idx[0];
    endtask

    task automatic test_enable_mask();
        logic [mem_geom_pkg::INDEX_W-1:0]    idx;
        logic [mem_geom_pkg::LINE_W-1:0]     got;
        logic [mem_ctrl_pkg::CFG_DATA_W-1:0] val;
        int                                  cycles;
        cfg_write(mem_ctrl_pkg::REG_CTRL, mem_ctrl_pkg::CTRL_RESET & ~32'h4);
        cfg_read(mem_ctrl_pkg::REG_CTRL, val);
        check_value("mask readback", mem_ctrl_pkg::CTRL_RESET & ~32'h4, val);
        idx = $urandom();
        @(posedge clk);
        we_rt[2]      <= 1'b1;
        addr_rt[2]    <= line_addr(idx);
        data_rt_in[2] <= rand_line();
        repeat (DISABLED_WAIT) begin
            @(negedge clk);
            if (rdy_rt[2])
                stop_on_error("Writer 2 was served while disabled");
        end
        cfg_write(mem_ctrl_pkg::REG_CTRL, mem_ctrl_pkg::CTRL_RESET);
        wait_write_ready(2);
        @(posedge clk);
        we_rt[2] <= 1'b0;
        read_line(idx, got, cycles);
        check_value("re-enabled write read", model[idx], got);
    endtask

    task automatic test_mc_first();
        logic [mem_geom_pkg::LINE_W-1:0] got;
        int                              cycles;
        cfg_write(mem_ctrl_pkg::REG_CTRL, mem_ctrl_pkg::CTRL_RESET | 32'h100);
        @(posedge clk);
        for (int i = 0; i < mem_ctrl_pkg::NUM_WR; i++) begin
            addr_rt[i]    <= line_addr(8'(i * 64 + 63));
            data_rt_in[i] <= rand_line();
        end
        we_rt <= '1;
        repeat (2) @(posedge clk);   // Writers keep the arbiter busy
        read_line(kept_idx, got, cycles);
        check_value("mc_first read latency", 2, cycles);
        check_value("mc_first read data", model[kept_idx], got);
        @(posedge clk);
        we_rt <= '0;
        cfg_write(mem_ctrl_pkg::REG_CTRL, mem_ctrl_pkg::CTRL_RESET);
    endtask

    task automatic test_write_count();
        logic [mem_ctrl_pkg::CFG_DATA_W-1:0] val;
        cfg_read(mem_ctrl_pkg::REG_WR_COUNT, val);
        check_value("write count", 32'(wr_pulses & 16'hFFFF), val);
        cfg_write(mem_ctrl_pkg::REG_WR_COUNT, $urandom());   // Read only, must be ignored
        cfg_read(mem_ctrl_pkg::REG_WR_COUNT, val);
        check_value("write count after register write", 32'(wr_pulses & 16'hFFFF), val);
    endtask

    // -------------------------------------------------------------------
    // Run
    // -------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        we_rt     = '0;
        re_mc     = 1'b0;
        addr_mc   = '0;
        cfg_we    = 1'b0;
        cfg_re    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        for (int i = 0; i < mem_ctrl_pkg::NUM_WR; i++) begin
            addr_rt[i]    = '0;
            data_rt_in[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_single();
        test_concurrent();
        test_enable_mask();
        test_mc_first();
        test_write_count();
        $display("** PASS **");
        $finish;
    end

endmodule : tb_mem_main

`default_nettype wire

//--- project.f
design/mem_geom_pkg.sv
design/mem_ctrl_pkg.sv
design/mem_access_if.sv
design/mem_arbiter.sv
design/mem_array.sv
design/mem_cfg_regs.sv
design/mem_main.sv
verification/mem_main_sva.sv
verification/tb_mem_main.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_main -f project.f -Mdir obj_dir \
    && ./obj_dir/Vtb_mem_main > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
